// File: mem_subsys_top.f
+incdir+.
mem_pkg.sv
sram_bus_if.sv
sram_model.sv
lsu_align.sv
mem_arbiter.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f mem_subsys_top.f \
  --top-module tb_mem_subsys \
  -o tb_mem_subsys_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

// File: tb_mem_subsys.sv
// Memory subsystem testbench
`include "mem_params.svh"

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 2000;  // Tests take a few hundred cycles
  localparam logic [31:0] BYTE_BASE  = 32'h0000_0100;
  localparam logic [31:0] FETCH_BASE = 32'h0000_0400;
  localparam logic [31:0] MIS_BASE   = 32'h0000_0800;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       fetch_req;
  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr;
  logic                       fetch_busy;
  logic                       fetch_valid;
  logic [`MEM_DATA_WIDTH-1:0] fetch_data;
  logic                       lsu_req;
  mem_pkg::lsu_op_e           lsu_op;
  logic [`MEM_ADDR_WIDTH-1:0] lsu_addr;
  logic [`MEM_DATA_WIDTH-1:0] lsu_wdata;
  logic                       lsu_done;
  logic [`MEM_DATA_WIDTH-1:0] lsu_rdata;
  logic                       lsu_misalign;

  logic [7:0]  shadow [4096] = '{default: 8'h00};  // Byte image of the memory
  integer      seed;
  int          errors = 0;
  int          checks = 0;
  int          cycles;
  logic [31:0] addr_a;
  logic [31:0] addr_b;
  logic [31:0] data;
  logic        exp_lsu;       // Responses due in the next cycle
  logic        exp_mis;
  logic [31:0] exp_lsu_data;
  logic        exp_fetch;
  logic [31:0] exp_fetch_data;
  logic        mis_now;
  logic        busy_now;

  mem_subsys_top mem_subsys_top_inst (
    .clk          (clk),
    .rst          (rst),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_busy   (fetch_busy),
    .fetch_valid  (fetch_valid),
    .fetch_data   (fetch_data),
    .lsu_req      (lsu_req),
    .lsu_op       (lsu_op),
    .lsu_addr     (lsu_addr),
    .lsu_wdata    (lsu_wdata),
    .lsu_done     (lsu_done),
    .lsu_rdata    (lsu_rdata),
    .lsu_misalign (lsu_misalign)
  );

  always #20 clk = ~clk;

  function automatic logic misaligned(input mem_pkg::lsu_op_e op, input logic [31:0] addr);
    case (op)
      mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: return addr[0];
      mem_pkg::LW, mem_pkg::SW: return addr[1] | addr[0];
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic store_op(input mem_pkg::lsu_op_e op);
    return op == mem_pkg::SB || op == mem_pkg::SH || op == mem_pkg::SW;
  endfunction

  // Expected load value, little endian
  function automatic logic [31:0] expected_load(input mem_pkg::lsu_op_e op,
                                                input logic [31:0] addr);
    logic [11:0] a;
    logic [7:0]  b;
    logic [15:0] h;
    a = addr[11:0];
    b = shadow[a];
    h = {shadow[a + 12'd1], shadow[a]};
    case (op)
      mem_pkg::LB:  return {{24{b[7]}}, b};
      mem_pkg::LBU: return {24'h0, b};
      mem_pkg::LH:  return {{16{h[15]}}, h};
      mem_pkg::LHU: return {16'h0, h};
      mem_pkg::LW:  return {shadow[a + 12'd3], shadow[a + 12'd2], h};
      default:      return 32'h0;
    endcase
  endfunction

  task automatic record_store(input mem_pkg::lsu_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
    logic [11:0] a;
    a = addr[11:0];
    shadow[a] = wdata[7:0];
    if (op != mem_pkg::SB) begin
      shadow[a + 12'd1] = wdata[15:8];
    end
    if (op == mem_pkg::SW) begin
      shadow[a + 12'd2] = wdata[23:16];
      shadow[a + 12'd3] = wdata[31:24];
    end
  endtask

  task automatic compare_responses();
    checks++;
    if (lsu_done !== exp_lsu) begin
      errors++;
      if (exp_lsu) $display("lsu_done missing one cycle after a request at %0t", $time);
      else $display("lsu_done pulsed with no request in flight at %0t", $time);
    end else if (exp_lsu && !exp_mis && lsu_rdata !== exp_lsu_data) begin
      errors++;
      $display("MISMATCH lsu_rdata expected %h got %h at %0t", exp_lsu_data, lsu_rdata, $time);
    end
    if (lsu_misalign !== (exp_lsu && exp_mis)) begin
      errors++;
      $display("MISMATCH lsu_misalign expected %h got %h at %0t",
               exp_lsu && exp_mis, lsu_misalign, $time);
    end
    if (fetch_valid !== exp_fetch) begin
      errors++;
      if (exp_fetch) $display("fetch_valid missing one cycle after a fetch at %0t", $time);
      else $display("fetch_valid pulsed with no fetch in flight at %0t", $time);
    end else if (exp_fetch && fetch_data !== exp_fetch_data) begin
      errors++;
      $display("MISMATCH fetch_data expected %h got %h at %0t", exp_fetch_data, fetch_data,
               $time);
    end
  endtask

  // Compare mid-cycle, then queue what the current inputs should give
  always @(negedge clk) begin
    if (rst) begin
      exp_lsu   = 1'b0;
      exp_mis   = 1'b0;
      exp_fetch = 1'b0;
    end else begin
      compare_responses();
      mis_now  = misaligned(lsu_op, lsu_addr);
      busy_now = fetch_req && lsu_req && !mis_now;  // Load/store wins the bus
      if (fetch_busy !== busy_now) begin
        errors++;
        $display("MISMATCH fetch_busy expected %h got %h at %0t", busy_now, fetch_busy, $time);
      end
      exp_lsu      = lsu_req;
      exp_mis      = lsu_req && mis_now;
      exp_lsu_data = 32'h0;  // Stores answer zero
      if (lsu_req && !mis_now) begin
        if (store_op(lsu_op)) record_store(lsu_op, lsu_addr, lsu_wdata);
        else exp_lsu_data = expected_load(lsu_op, lsu_addr);
      end
      exp_fetch      = fetch_req && !busy_now;
      exp_fetch_data = expected_load(mem_pkg::LW, {fetch_addr[31:2], 2'b00});
    end
  end

  task automatic issue(input logic l_req, input mem_pkg::lsu_op_e op, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic f_req, input logic [31:0] faddr);
    @(posedge clk);
    #2;
    lsu_req    = l_req;
    lsu_op     = op;
    lsu_addr   = addr;
    lsu_wdata  = wdata;
    fetch_req  = f_req;
    fetch_addr = faddr;
  endtask

  task automatic lsu_access(input mem_pkg::lsu_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
    issue(1'b1, op, addr, wdata, 1'b0, 32'h0);
  endtask

  task automatic fetch_word(input logic [31:0] addr);
    issue(1'b0, mem_pkg::LW, 32'h0, 32'h0, 1'b1, addr);
  endtask

  task automatic idle(input int n);
    repeat (n) issue(1'b0, mem_pkg::LW, 32'h0, 32'h0, 1'b0, 32'h0);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    lsu_req    = 1'b0;
    lsu_op     = mem_pkg::LW;
    lsu_addr   = '0;
    lsu_wdata  = '0;
    seed       = 40;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    // Quiet after reset, zeros everywhere
    idle(3);
    lsu_access(mem_pkg::LW, 32'h0, 32'h0);
    lsu_access(mem_pkg::LB, 32'h7, 32'h0);
    lsu_access(mem_pkg::LHU, 32'h3fe, 32'h0);
    fetch_word(32'h40);
    idle(2);

    for (int i = 0; i < 32; i++) begin
      addr_a = $random(seed) & 32'h0ffc;
      addr_b = $random(seed) & 32'h0ffc;
      data   = $random(seed);
      lsu_access(mem_pkg::SW, addr_a, data);
      lsu_access(mem_pkg::LW, addr_a, 32'h0);
      lsu_access(mem_pkg::LW, addr_b, 32'h0);
    end

    // Byte lanes, both sign bit values
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 2; k++) begin
        data    = $random(seed);
        data[7] = k[0];
        lsu_access(mem_pkg::SB, BYTE_BASE + off, data);
        lsu_access(mem_pkg::LB, BYTE_BASE + off, 32'h0);
        lsu_access(mem_pkg::LBU, BYTE_BASE + off, 32'h0);
        lsu_access(mem_pkg::LW, BYTE_BASE, 32'h0);
      end
    end
    for (int off = 0; off < 4; off += 2) begin
      for (int k = 0; k < 2; k++) begin
        data     = $random(seed);
        data[15] = k[0];
        lsu_access(mem_pkg::SH, BYTE_BASE + off, data);
        lsu_access(mem_pkg::LH, BYTE_BASE + off, 32'h0);
        lsu_access(mem_pkg::LHU, BYTE_BASE + off, 32'h0);
        lsu_access(mem_pkg::LB, BYTE_BASE + off + 1, 32'h0);
        lsu_access(mem_pkg::LW, BYTE_BASE, 32'h0);
      end
    end

    // Fetch sees stored words, collisions then retries
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      lsu_access(mem_pkg::SW, FETCH_BASE + 4 * i, data);
    end
    for (int i = 0; i < 8; i++) begin
      fetch_word(FETCH_BASE + 4 * i);
    end
    data = $random(seed);
    issue(1'b1, mem_pkg::SW, FETCH_BASE, data, 1'b1, FETCH_BASE + 4);
    fetch_word(FETCH_BASE + 4);
    issue(1'b1, mem_pkg::LW, FETCH_BASE, 32'h0, 1'b1, FETCH_BASE);
    fetch_word(FETCH_BASE);
    issue(1'b1, mem_pkg::LB, FETCH_BASE + 1, 32'h0, 1'b1, FETCH_BASE + 8);
    fetch_word(FETCH_BASE + 8);

    // Misaligned accesses leave memory alone
    data = $random(seed);
    lsu_access(mem_pkg::SW, MIS_BASE, data);
    lsu_access(mem_pkg::LH, MIS_BASE + 1, 32'h0);
    lsu_access(mem_pkg::LHU, MIS_BASE + 3, 32'h0);
    lsu_access(mem_pkg::LW, MIS_BASE + 2, 32'h0);
    lsu_access(mem_pkg::SH, MIS_BASE + 1, $random(seed));
    lsu_access(mem_pkg::SW, MIS_BASE + 3, $random(seed));
    lsu_access(mem_pkg::SW, MIS_BASE + 2, $random(seed));
    issue(1'b1, mem_pkg::SW, MIS_BASE + 1, 32'hffff_ffff, 1'b1, MIS_BASE);
    lsu_access(mem_pkg::LW, MIS_BASE, 32'h0);
    for (int off = 0; off < 4; off++) begin
      lsu_access(mem_pkg::LBU, MIS_BASE + off, 32'h0);
    end
    idle(3);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: mem_subsys_top.sv
// Memory subsystem top level
`include "mem_params.svh"

module mem_subsys_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_req,
  input  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr,
  output logic                       fetch_busy,
  output logic                       fetch_valid,
  output logic [`MEM_DATA_WIDTH-1:0] fetch_data,
  input  logic                       lsu_req,
  input  mem_pkg::lsu_op_e           lsu_op,
  input  logic [`MEM_ADDR_WIDTH-1:0] lsu_addr,
  input  logic [`MEM_DATA_WIDTH-1:0] lsu_wdata,
  output logic                       lsu_done,
  output logic [`MEM_DATA_WIDTH-1:0] lsu_rdata,
  output logic                       lsu_misalign
);

  // Aligner to arbiter
  logic                       lsu_mem_rd;
  logic                       lsu_mem_wt;
  logic [`MEM_ADDR_WIDTH-1:0] lsu_mem_addr;
  logic [`MEM_DATA_WIDTH-1:0] lsu_mem_wdata;
  logic [`MEM_MASK_WIDTH-1:0] lsu_mem_wmask;
  logic [`MEM_DATA_WIDTH-1:0] lsu_mem_rdata;
  logic                       lsu_mem_done;

  sram_bus_if mem_bus ();

  lsu_align lsu_align_inst (
    .clk          (clk),
    .rst          (rst),
    .lsu_req      (lsu_req),
    .lsu_op       (lsu_op),
    .lsu_addr     (lsu_addr),
    .lsu_wdata    (lsu_wdata),
    .lsu_rdata    (lsu_rdata),
    .lsu_done     (lsu_done),
    .lsu_misalign (lsu_misalign),
    .mem_rd       (lsu_mem_rd),
    .mem_wt       (lsu_mem_wt),
    .mem_addr     (lsu_mem_addr),
    .mem_wdata    (lsu_mem_wdata),
    .mem_wmask    (lsu_mem_wmask),
    .mem_rdata    (lsu_mem_rdata),
    .mem_done     (lsu_mem_done)
  );

  mem_arbiter mem_arbiter_inst (
    .clk         (clk),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_busy  (fetch_busy),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .lsu_rd      (lsu_mem_rd),
    .lsu_wt      (lsu_mem_wt),
    .lsu_addr    (lsu_mem_addr),
    .lsu_wdata   (lsu_mem_wdata),
    .lsu_wmask   (lsu_mem_wmask),
    .lsu_rdata   (lsu_mem_rdata),
    .lsu_done    (lsu_mem_done),
    .bus         (mem_bus.requester)
  );

  sram_model sram_model_inst (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.memory)
  );

endmodule

// File: mem_arbiter.sv
// Fixed-priority arbiter, load/store over fetch
`include "mem_params.svh"

module mem_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_req,
  input  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr,
  output logic                       fetch_busy,
  output logic [`MEM_DATA_WIDTH-1:0] fetch_data,
  output logic                       fetch_valid,
  input  logic                       lsu_rd,
  input  logic                       lsu_wt,
  input  logic [`MEM_ADDR_WIDTH-1:0] lsu_addr,
  input  logic [`MEM_DATA_WIDTH-1:0] lsu_wdata,
  input  logic [`MEM_MASK_WIDTH-1:0] lsu_wmask,
  output logic [`MEM_DATA_WIDTH-1:0] lsu_rdata,
  output logic                       lsu_done,
  sram_bus_if.requester              bus
);

  logic                si_lsu;        // Load/store wants the bus
  logic                fetch_go;      // Fetch granted this cycle
  logic                resp;
  mem_pkg::bus_owner_e owner_q;

  assign si_lsu     = lsu_rd || lsu_wt;
  assign fetch_go   = fetch_req && !si_lsu;
  assign fetch_busy = fetch_req && si_lsu;  // Refused, core retries

  // Forward the granted request
  assign bus.rd_req_valid = lsu_rd || fetch_go;
  assign bus.addr         = si_lsu ? lsu_addr : fetch_addr;
  assign bus.wt_req_valid = lsu_wt;
  assign bus.waddr        = lsu_addr;
  assign bus.wdata        = lsu_wdata;
  assign bus.wmask        = lsu_wmask;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner_q <= mem_pkg::OWNER_NONE;
    end else if (si_lsu) begin
      owner_q <= mem_pkg::OWNER_LSU;
    end else if (fetch_go) begin
      owner_q <= mem_pkg::OWNER_FETCH;
    end else begin
      owner_q <= mem_pkg::OWNER_NONE;
    end
  end

  // Steer the response to its owner
  assign resp        = bus.rd_res_valid || bus.wt_res_valid;
  assign fetch_valid = resp && (owner_q == mem_pkg::OWNER_FETCH);
  assign lsu_done    = resp && (owner_q == mem_pkg::OWNER_LSU);
  assign fetch_data  = bus.data_out;
  assign lsu_rdata   = bus.data_out;

  a_resp_has_owner: assert property (@(posedge clk) disable iff (rst)
    resp |-> owner_q != mem_pkg::OWNER_NONE);

endmodule

// File: lsu_align.sv
// Load/store alignment and load extension
`include "mem_params.svh"

module lsu_align (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       lsu_req,
  input  mem_pkg::lsu_op_e           lsu_op,
  input  logic [`MEM_ADDR_WIDTH-1:0] lsu_addr,
  input  logic [`MEM_DATA_WIDTH-1:0] lsu_wdata,
  output logic [`MEM_DATA_WIDTH-1:0] lsu_rdata,
  output logic                       lsu_done,
  output logic                       lsu_misalign,
  output logic                       mem_rd,
  output logic                       mem_wt,
  output logic [`MEM_ADDR_WIDTH-1:0] mem_addr,
  output logic [`MEM_DATA_WIDTH-1:0] mem_wdata,
  output logic [`MEM_MASK_WIDTH-1:0] mem_wmask,
  input  logic [`MEM_DATA_WIDTH-1:0] mem_rdata,
  input  logic                       mem_done
);

  logic                       is_store;
  logic                       misalign;
  logic                       issued_q;    // Request went to memory
  logic                       misalign_q;
  mem_pkg::lsu_op_e           op_q;
  logic [1:0]                 off_q;       // Byte offset in the word
  logic [`MEM_DATA_WIDTH-1:0] lane;

  // Decode and alignment check
  always_comb begin
    is_store = 1'b0;
    misalign = 1'b0;
    case (lsu_op)
      mem_pkg::LH, mem_pkg::LHU: misalign = lsu_addr[0];
      mem_pkg::LW: misalign = |lsu_addr[1:0];
      mem_pkg::SB: is_store = 1'b1;
      mem_pkg::SH: begin
        is_store = 1'b1;
        misalign = lsu_addr[0];
      end
      mem_pkg::SW: begin
        is_store = 1'b1;
        misalign = |lsu_addr[1:0];
      end
      default: ;
    endcase
  end

  assign mem_rd   = lsu_req && !is_store && !misalign;
  assign mem_wt   = lsu_req && is_store && !misalign;
  assign mem_addr = {lsu_addr[`MEM_ADDR_WIDTH-1:2], 2'b00};

  // Store lanes and byte enables
  always_comb begin
    mem_wmask = '0;
    mem_wdata = lsu_wdata;
    case (lsu_op)
      mem_pkg::SB: begin
        mem_wmask = 4'b0001 << lsu_addr[1:0];
        mem_wdata = {4{lsu_wdata[7:0]}};
      end
      mem_pkg::SH: begin
        mem_wmask = 4'b0011 << lsu_addr[1:0];
        mem_wdata = {2{lsu_wdata[15:0]}};
      end
      mem_pkg::SW: mem_wmask = '1;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      issued_q   <= 1'b0;
      misalign_q <= 1'b0;
    end else begin
      issued_q   <= mem_rd || mem_wt;
      misalign_q <= lsu_req && misalign;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_req) begin
      op_q  <= lsu_op;
      off_q <= lsu_addr[1:0];
    end
  end

  // Load lane select and extension
  always_comb begin
    lane      = mem_rdata >> {off_q, 3'b000};
    lsu_rdata = '0;
    if (mem_done) begin
      case (op_q)
        mem_pkg::LB:  lsu_rdata = {{(`MEM_DATA_WIDTH-8){lane[7]}}, lane[7:0]};
        mem_pkg::LBU: lsu_rdata = {{(`MEM_DATA_WIDTH-8){1'b0}}, lane[7:0]};
        mem_pkg::LH:  lsu_rdata = {{(`MEM_DATA_WIDTH-16){lane[15]}}, lane[15:0]};
        mem_pkg::LHU: lsu_rdata = {{(`MEM_DATA_WIDTH-16){1'b0}}, lane[15:0]};
        mem_pkg::LW:  lsu_rdata = mem_rdata;
        default: ;    // Stores return zero
      endcase
    end
  end

  assign lsu_done     = mem_done || misalign_q;
  assign lsu_misalign = misalign_q;

  // Memory answers only what was issued the cycle before
  a_done_follows_issue: assert property (@(posedge clk) disable iff (rst)
    mem_done |-> issued_q && !misalign_q);

endmodule

// File: sram_model.sv
// Single-port word memory, one cycle latency
`include "mem_params.svh"

module sram_model (
  input  logic       clk,
  input  logic       rst,
  sram_bus_if.memory bus
);

  localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

  logic [`MEM_DATA_WIDTH-1:0] mem [DEPTH];

  logic                       rd_q;      // Registered strobes
  logic                       wt_q;
  logic [`MEM_DEPTH_LOG2-1:0] raddr_q;   // Word index only
  logic [`MEM_DEPTH_LOG2-1:0] waddr_q;
  logic [`MEM_DATA_WIDTH-1:0] wdata_q;
  logic [`MEM_MASK_WIDTH-1:0] wmask_q;
  logic [`MEM_DATA_WIDTH-1:0] merged;    // Old word with new bytes
  logic                       do_write;

  // Contents start at zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_q <= 1'b0;
      wt_q <= 1'b0;
    end else begin
      rd_q <= bus.rd_req_valid;
      wt_q <= bus.wt_req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.rd_req_valid) begin
      raddr_q <= bus.addr[`MEM_DEPTH_LOG2+1:2];
    end
    if (bus.wt_req_valid) begin
      waddr_q <= bus.waddr[`MEM_DEPTH_LOG2+1:2];
      wdata_q <= bus.wdata;
      wmask_q <= bus.wmask;
    end
  end

  // Byte merge of the pending write
  always_comb begin
    merged = mem[waddr_q];
    for (int b = 0; b < `MEM_MASK_WIDTH; b++) begin
      if (wmask_q[b]) begin
        merged[8*b +: 8] = wdata_q[8*b +: 8];
      end
    end
  end

  assign do_write = wt_q && !rd_q;  // Read wins

  // Array takes the write at the end of the response cycle
  always @(posedge clk) begin
    if (do_write) begin
      mem[waddr_q] <= merged;
    end
  end

  assign bus.rd_res_valid = rd_q;
  assign bus.wt_res_valid = wt_q;
  assign bus.data_out     = rd_q ? mem[raddr_q] : (do_write ? merged : '0);

  a_one_request: assert property (@(posedge clk) disable iff (rst)
    !(bus.rd_req_valid && bus.wt_req_valid));

  a_one_response: assert property (@(posedge clk) disable iff (rst)
    $onehot0({bus.rd_res_valid, bus.wt_res_valid}));

endmodule

// File: sram_bus_if.sv
// Memory request and response bus
`include "mem_params.svh"

interface sram_bus_if;

  // Read request
  logic                       rd_req_valid;
  logic [`MEM_ADDR_WIDTH-1:0] addr;

  // Write request
  logic                       wt_req_valid;
  logic [`MEM_ADDR_WIDTH-1:0] waddr;
  logic [`MEM_DATA_WIDTH-1:0] wdata;
  logic [`MEM_MASK_WIDTH-1:0] wmask;

  // Response, one cycle after the strobe
  logic [`MEM_DATA_WIDTH-1:0] data_out;
  logic                       rd_res_valid;
  logic                       wt_res_valid;

  modport requester (
    output rd_req_valid, addr,
    output wt_req_valid, waddr, wdata, wmask,
    input  data_out, rd_res_valid, wt_res_valid
  );

  modport memory (
    input  rd_req_valid, addr,
    input  wt_req_valid, waddr, wdata, wmask,
    output data_out, rd_res_valid, wt_res_valid
  );

endinterface

// File: mem_pkg.sv
// Memory subsystem types
package mem_pkg;

  // Load/store operations, loads first
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  // Owner of the response in flight
  typedef enum logic [1:0] {
    OWNER_NONE  = 2'd0,
    OWNER_FETCH = 2'd1,
    OWNER_LSU   = 2'd2
  } bus_owner_e;

endpackage

// File: mem_params.svh
// Memory subsystem parameters
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Word width in bits
`define MEM_DATA_WIDTH 32

// Byte address width on every port
`define MEM_ADDR_WIDTH 32

// Words stored in the memory model, as log2
`define MEM_DEPTH_LOG2 10

// One enable per byte of a word
`define MEM_MASK_WIDTH 4

`endif
